//--- compile.f
fetch_pkg.sv
pc_gen.sv
icache_array.sv
ifu.sv
fetch_top.sv
tb_fetch.sv

//--- fetch_pkg.sv
package fetch_pkg;

  // ****************************************
  // basic widths
  // ****************************************

  // byte address, only word aligned values are fetched.
  typedef logic [31:0] addr_t;

  // one 32-bit instruction word.
  typedef logic [31:0] inst_t;

  // ****************************************
  // fetch control
  // ****************************************

  typedef enum logic [1:0] {
    FETCH_IDLE,    // first cycle out of reset.
    FETCH_LOOKUP,  // pc taken, cache checked.
    FETCH_MISS,    // read outstanding on the memory port.
    FETCH_HOLD     // item presented, waiting for decode.
  } fetch_state_t;

  // ****************************************
  // decode side payload
  // ****************************************

  // Item handed to decode, 64 bits.
  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fetch_out_t;

endpackage

//--- fetch_top.sv
`timescale 1ns/1ns

module fetch_top
  import fetch_pkg::*;
#(
  parameter int    IDX_W    = 8,
  parameter addr_t RESET_PC = 32'h8000_0000
) (
  input  logic       clk,
  input  logic       rst,
  // control flow change from the back end.
  input  logic       redirect_i,
  input  addr_t      redirect_pc_i,
  // memory read port.
  output logic       mem_arvalid_o,
  output addr_t      mem_araddr_o,
  input  logic       mem_rvalid_i,
  input  inst_t      mem_rdata_i,
  // decode side.
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output fetch_out_t out_o
);

  addr_t pc;
  logic  pc_take;
  logic  flush;
  addr_t lookup_addr;
  logic  hit;
  inst_t hit_data;
  logic  fill_en;
  addr_t fill_addr;
  inst_t fill_data;

  pc_gen #(
    .RESET_PC (RESET_PC)
  ) i_pc_gen (
    .clk           (clk),
    .rst           (rst),
    .pc_take_i     (pc_take),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .pc_o          (pc),
    .flush_o       (flush)
  );

  ifu #(
    .IDX_W (IDX_W)
  ) i_ifu (
    .clk           (clk),
    .rst           (rst),
    .pc_i          (pc),
    .flush_i       (flush),
    .pc_take_o     (pc_take),
    .lookup_addr_o (lookup_addr),
    .hit_i         (hit),
    .hit_data_i    (hit_data),
    .fill_en_o     (fill_en),
    .fill_addr_o   (fill_addr),
    .fill_data_o   (fill_data),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_araddr_o  (mem_araddr_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .out_o         (out_o)
  );

  icache_array #(
    .IDX_W (IDX_W)
  ) i_icache (
    .clk           (clk),
    .rst           (rst),
    .lookup_addr_i (lookup_addr),
    .hit_o         (hit),
    .hit_data_o    (hit_data),
    .fill_en_i     (fill_en),
    .fill_addr_i   (fill_addr),
    .fill_data_i   (fill_data)
  );

endmodule

//--- icache_array.sv
`timescale 1ns/1ns

module icache_array
  import fetch_pkg::*;
#(
  parameter int IDX_W = 8
) (
  input  logic  clk,
  input  logic  rst,
  // lookup port, combinational.
  input  addr_t lookup_addr_i,
  output logic  hit_o,
  output inst_t hit_data_o,
  // fill port, written on the clock edge.
  input  logic  fill_en_i,
  input  addr_t fill_addr_i,
  input  inst_t fill_data_i
);

  localparam int TAG_W = 30 - IDX_W;
  localparam int LINES = 2 ** IDX_W;

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0] tag_t;

  // ****************************************
  // storage
  // ****************************************

  tag_t             tag_mem  [LINES];
  inst_t            data_mem [LINES];
  logic [LINES-1:0] valid_q;

  idx_t lookup_idx;
  tag_t lookup_tag;
  idx_t fill_idx;
  tag_t fill_tag;

  // ****************************************
  // address split
  // ****************************************

  // bits 1..0 are the byte offset and play no part.
  assign lookup_idx = lookup_addr_i[IDX_W+1:2];
  assign lookup_tag = lookup_addr_i[31:IDX_W+2];
  assign fill_idx   = fill_addr_i[IDX_W+1:2];
  assign fill_tag   = fill_addr_i[31:IDX_W+2];

  // ****************************************
  // lookup
  // ****************************************

  assign hit_o      = valid_q[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
  assign hit_data_o = data_mem[lookup_idx];

  // ****************************************
  // fill
  // ****************************************

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= '0;
    end
    else if (fill_en_i)
    begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

  // a fill replaces whatever line sat at this index.
  always_ff @(posedge clk)
  begin
    if (fill_en_i)
    begin
      tag_mem[fill_idx]  <= fill_tag;
      data_mem[fill_idx] <= fill_data_i;
    end
  end

  a_fill_known: assert property (@(posedge clk) disable iff (rst)
    fill_en_i |-> !$isunknown(fill_data_i))
    else $error("icache_array: fill of line %0d with unknown data", fill_idx);

endmodule

//--- ifu.sv
`timescale 1ns/1ns

module ifu
  import fetch_pkg::*;
#(
  parameter int IDX_W = 8
) (
  input  logic       clk,
  input  logic       rst,
  // pc generator.
  input  addr_t      pc_i,
  input  logic       flush_i,
  output logic       pc_take_o,
  // cache array.
  output addr_t      lookup_addr_o,
  input  logic       hit_i,
  input  inst_t      hit_data_i,
  output logic       fill_en_o,
  output addr_t      fill_addr_o,
  output inst_t      fill_data_o,
  // memory read port.
  output logic       mem_arvalid_o,
  output addr_t      mem_araddr_o,
  input  logic       mem_rvalid_i,
  input  inst_t      mem_rdata_i,
  // decode side.
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output fetch_out_t out_o
);

  fetch_state_t state_q;
  fetch_state_t state_d;
  addr_t        req_q;      // pc of the fetch in progress.
  fetch_out_t   out_q;
  logic         load_hit;
  logic         load_fill;

  // ****************************************
  // state machine
  // ****************************************

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      FETCH_IDLE:
      begin
        state_d = FETCH_LOOKUP;
      end
      FETCH_LOOKUP:
      begin
        // a flushed take only moves the pc to the new path.
        if (!flush_i)
        begin
          state_d = hit_i ? FETCH_HOLD : FETCH_MISS;
        end
      end
      FETCH_MISS:
      begin
        if (mem_rvalid_i)
        begin
          state_d = flush_i ? FETCH_LOOKUP : FETCH_HOLD;
        end
      end
      FETCH_HOLD:
      begin
        if (out_ready_i)
        begin
          state_d = FETCH_LOOKUP;
        end
      end
      default:
      begin
        state_d = FETCH_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= FETCH_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // ****************************************
  // datapath
  // ****************************************

  assign pc_take_o = (state_q == FETCH_LOOKUP);
  assign load_hit  = pc_take_o && !flush_i && hit_i;
  assign load_fill = fill_en_o && !flush_i;  // stale words fill the cache only.

  always_ff @(posedge clk)
  begin
    if (pc_take_o && !flush_i)
    begin
      req_q <= pc_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load_hit)
    begin
      out_q <= '{pc: pc_i, inst: hit_data_i};
    end
    else if (load_fill)
    begin
      out_q <= '{pc: req_q, inst: mem_rdata_i};
    end
  end

  // while a fetch is open the cache port points at its own pc.
  assign lookup_addr_o = (state_q inside {FETCH_MISS, FETCH_HOLD}) ? req_q : pc_i;

  assign mem_arvalid_o = (state_q == FETCH_MISS);
  assign mem_araddr_o  = req_q;

  assign fill_en_o   = mem_arvalid_o && mem_rvalid_i;
  assign fill_addr_o = req_q;
  assign fill_data_o = mem_rdata_i;

  assign out_valid_o = (state_q == FETCH_HOLD);
  assign out_o       = out_q;

  // ****************************************
  // checks
  // ****************************************

  a_ar_stable: assert property (@(posedge clk) disable iff (rst)
    (mem_arvalid_o && !mem_rvalid_i) |=> (mem_arvalid_o && $stable(mem_araddr_o)))
    else $error("ifu: read request dropped or changed before rvalid");

  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_o)))
    else $error("ifu: output changed while decode stalled");

endmodule

//--- pc_gen.sv
`timescale 1ns/1ns

module pc_gen
  import fetch_pkg::*;
#(
  parameter addr_t RESET_PC = 32'h8000_0000
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  pc_take_i,      // ifu accepted pc_o this cycle.
  input  logic  redirect_i,
  input  addr_t redirect_pc_i,
  output addr_t pc_o,
  output logic  flush_o         // fetch in flight is on the old path.
);

  addr_t pc_q;
  addr_t target_q;
  addr_t next_pc;
  logic  pending_q;

  // ****************************************
  // next pc
  // ****************************************

  // a live redirect wins over one that is still pending.
  always_comb
  begin
    if (redirect_i)
    begin
      next_pc = redirect_pc_i;
    end
    else if (pending_q)
    begin
      next_pc = target_q;
    end
    else
    begin
      next_pc = pc_q + 32'd4;
    end
  end

  assign flush_o = redirect_i | pending_q;
  assign pc_o    = pc_q;

  // ****************************************
  // registers
  // ****************************************

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q      <= RESET_PC;
      pending_q <= 1'b0;
    end
    else if (pc_take_i)
    begin
      pc_q      <= next_pc;
      pending_q <= 1'b0;  // redirect consumed by this take.
    end
    else if (redirect_i)
    begin
      pending_q <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (redirect_i)
    begin
      target_q <= redirect_pc_i;
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc_o[1:0] == 2'b00)
    else $error("pc_gen: fetch pc %h is not word aligned", pc_o);

endmodule

//--- run_sim.sh
#!/bin/sh
# build the fetch stage testbench with verilator and run it.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_fetch -o tb_fetch
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_fetch > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
  exit 1
fi
exit 0

//--- tb_fetch.sv
`timescale 1ns/1ns

module tb_fetch
  import fetch_pkg::*;
();

  localparam int    CLK_PERIOD  = 100;
  localparam int    DRIVE_DLY   = 10;
  localparam int    IDX_W       = 8;
  localparam int    TAG_W       = 30 - IDX_W;
  localparam addr_t RESET_PC    = 32'h8000_0000;
  localparam inst_t CONTENT_KEY = 32'h5a5a_a5a5;
  localparam int    SEED        = 32'h0068_ba12;
  localparam int    NROWS       = 11;
  localparam int    TIMEOUT_CYC = NROWS * 200 + 16;

  localparam logic [1:0] REDIR_NONE = 2'd0;
  localparam logic [1:0] REDIR_NOW  = 2'd1;  // unit is in lookup, nothing in flight.
  localparam logic [1:0] REDIR_MISS = 2'd2;  // wait for an outstanding read first.

  typedef struct packed {
    logic [1:0] redir;
    addr_t      target;
    logic [7:0] count;   // items to consume.
    logic [7:0] stall;   // ready is low when the picked bit is set.
  } row_t;

  // a 1 KiB step keeps the index and changes the tag.
  row_t rows [NROWS] = '{
    '{REDIR_NONE, 32'h0000_0000, 8'd8,  8'h00},
    '{REDIR_NOW,  32'h8000_0000, 8'd8,  8'h00},
    '{REDIR_NOW,  32'h8000_0400, 8'd1,  8'h00},
    '{REDIR_NOW,  32'h8000_0000, 8'd2,  8'h00},
    '{REDIR_NOW,  32'h8000_1000, 8'd4,  8'h00},
    '{REDIR_MISS, 32'h8000_2000, 8'd3,  8'h00},
    '{REDIR_NOW,  32'h8000_1010, 8'd1,  8'h00},
    '{REDIR_NONE, 32'h0000_0000, 8'd24, 8'h49},
    '{REDIR_NOW,  32'h8000_1000, 8'd16, 8'h3c},
    '{REDIR_NOW,  32'h8000_3000, 8'd2,  8'h0f},
    '{REDIR_MISS, 32'h8000_0400, 8'd4,  8'h11}
  };

  logic       clk;
  logic       rst;
  logic       redirect_i;
  addr_t      redirect_pc_i;
  logic       mem_arvalid_o;
  addr_t      mem_araddr_o;
  logic       mem_rvalid_i;
  inst_t      mem_rdata_i;
  logic       out_valid_o;
  logic       out_ready_i;
  fetch_out_t out_o;

  // reference cache contents and expected stream.
  logic             line_valid [2**IDX_W];
  logic [TAG_W-1:0] line_tag   [2**IDX_W];
  addr_t            exp_pc;
  int               exp_req;
  int               req_count;
  int               err_fetch;
  int               err_count;
  int               err_flag;

  fetch_top #(
    .IDX_W    (IDX_W),
    .RESET_PC (RESET_PC)
  ) i_dut (
    .clk           (clk),
    .rst           (rst),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_araddr_o  (mem_araddr_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .out_o         (out_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic inst_t word_at(input addr_t a);
    return a ^ CONTENT_KEY;
  endfunction

  // a miss in the reference cache costs one memory request.
  task automatic model_fetch(input addr_t pc);
    logic [IDX_W-1:0] idx;
    idx = pc[IDX_W+1:2];
    if (!(line_valid[idx] && line_tag[idx] == pc[31:IDX_W+2]))
    begin
      exp_req++;
      line_valid[idx] = 1'b1;
      line_tag[idx]   = pc[31:IDX_W+2];
    end
  endtask

  // ****************************************
  // compare tasks
  // ****************************************

  task automatic check_fetch(input fetch_out_t got, input fetch_out_t exp);
    if (got !== exp)
    begin
      err_fetch++;
      $display("ERR %0t: item pc %h inst %h, expected pc %h inst %h",
               $time, got.pc, got.inst, exp.pc, exp.inst);
    end
  endtask

  task automatic check_count(input int got, input int exp);
    if (got != exp)
    begin
      err_count++;
      $display("ERR %0t: %0d memory requests, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      err_flag++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // ****************************************
  // memory model
  // ****************************************

  initial
  begin : memory_model
    int unsigned wait_cyc;
    logic        busy;
    addr_t       addr;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    req_count    = 0;
    busy         = 1'b0;
    forever
    begin
      @(posedge clk);
      #DRIVE_DLY;
      mem_rvalid_i = 1'b0;
      if (rst)
      begin
        busy = 1'b0;
      end
      else if (busy)
      begin
        wait_cyc--;
        if (wait_cyc == 0)
        begin
          mem_rvalid_i = 1'b1;
          mem_rdata_i  = word_at(addr);
          busy         = 1'b0;
        end
      end
      else if (mem_arvalid_o)
      begin
        busy     = 1'b1;
        addr     = mem_araddr_o;
        wait_cyc = 1 + ($urandom % 4);  // 1 to 4 cycles.
        req_count++;
      end
    end
  end

  // ****************************************
  // stimulus
  // ****************************************

  task automatic run_row(input row_t row);
    int         got;
    logic       redir_done;
    logic [2:0] pick;
    fetch_out_t exp_item;
    got        = 0;
    redir_done = (row.redir == REDIR_NONE);
    while (got < int'(row.count))
    begin
      @(posedge clk);
      #DRIVE_DLY;
      redirect_i  = 1'b0;
      out_ready_i = 1'b0;
      if (!redir_done)
      begin
        if (row.redir == REDIR_NOW || mem_arvalid_o)
        begin
          if (row.redir == REDIR_MISS)
          begin
            model_fetch(exp_pc);  // the stale read still fills its line.
          end
          redirect_i    = 1'b1;
          redirect_pc_i = row.target;
          exp_pc        = row.target;
          redir_done    = 1'b1;
        end
      end
      else
      begin
        pick        = 3'($urandom);
        out_ready_i = !row.stall[pick];
        if (out_valid_o && out_ready_i)
        begin
          exp_item.pc   = exp_pc;
          exp_item.inst = word_at(exp_pc);
          check_fetch(out_o, exp_item);
          model_fetch(exp_pc);
          exp_pc = exp_pc + 32'd4;
          got++;
        end
      end
    end
    check_count(req_count, exp_req);
  endtask

  initial
  begin : main
    int unsigned seed_ret;
    seed_ret      = $urandom(SEED);
    rst           = 1'b1;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    out_ready_i   = 1'b0;
    exp_pc        = RESET_PC;
    exp_req       = 0;
    err_fetch     = 0;
    err_count     = 0;
    err_flag      = 0;
    foreach (line_valid[i])
    begin
      line_valid[i] = 1'b0;
    end
    repeat (16) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;
    check_flag(out_valid_o, 1'b0, "out_valid_o after reset");
    check_flag(mem_arvalid_o, 1'b0, "mem_arvalid_o after reset");
    foreach (rows[r])
    begin
      run_row(rows[r]);
    end
    $display("errors: %0d (fetch %0d, count %0d, flag %0d)",
             err_fetch + err_count + err_flag, err_fetch, err_count, err_flag);
    if (err_fetch + err_count + err_flag == 0)
    begin
      $display("TESTBENCH PASSED");
    end
    else
    begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial
  begin : watchdog
    #(TIMEOUT_CYC * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYC);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
